// File: Bender.yml
package:
  name: decode_exec_top

sources:
  - rtl/la_core_pkg.sv
  - rtl/la_alu.sv
  - rtl/la_decoder.sv
  - rtl/uop_fifo.sv
  - rtl/exec_unit.sv
  - rtl/decode_exec_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_decode_exec.sv

// File: decode_exec_top.f
rtl/la_core_pkg.sv
rtl/la_alu.sv
rtl/la_decoder.sv
rtl/uop_fifo.sv
rtl/exec_unit.sv
rtl/decode_exec_top.sv
+incdir+test
test/tb_decode_exec.sv

// File: rtl/decode_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_exec_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                fetch_valid,
    input  wire la_core_pkg::fetch_t fetch,
    output logic                     fetch_ready,
    output logic                     wb_valid,
    output la_core_pkg::wb_t         wb,
    input  wire logic                wb_ready
);

    logic              uop_valid;
    logic              uop_ready;
    la_core_pkg::uop_t uop;
    logic              issue_valid;
    logic              issue_ready;
    la_core_pkg::uop_t issue_uop;

    la_decoder decoder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .uop_valid   (uop_valid),
        .uop         (uop),
        .uop_ready   (uop_ready)
    );

    uop_fifo fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (uop_valid),
        .in_uop    (uop),
        .in_ready  (uop_ready),
        .out_valid (issue_valid),
        .out_uop   (issue_uop),
        .out_ready (issue_ready)
    );

    exec_unit exec_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .wb_ready    (wb_ready)
    );

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              issue_valid,
    input  wire la_core_pkg::uop_t issue_uop,
    output logic                   issue_ready,
    output logic                   wb_valid,
    output la_core_pkg::wb_t       wb,
    input  wire logic              wb_ready
);

    logic [la_core_pkg::xlen-1:0] rf [2**la_core_pkg::reg_addr_w];
    logic [la_core_pkg::xlen-1:0] src1;
    logic [la_core_pkg::xlen-1:0] src2;
    logic [la_core_pkg::xlen-1:0] alu_result;
    logic                         issue;
    logic                         rf_we;

    // wb slot empty or draining
    assign issue_ready = !wb_valid || wb_ready;
    assign issue       = issue_valid && issue_ready;
    assign rf_we       = issue && issue_uop.reg_write_en && (issue_uop.rd_addr != '0);

    assign src1 = rf[issue_uop.rj_addr];
    assign src2 = issue_uop.use_rk ? rf[issue_uop.rk_addr] : issue_uop.imm;

    la_alu alu_i (
        .op     (issue_uop.op),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**la_core_pkg::reg_addr_w; i++)
                rf[i] <= '0;
        end else if (rf_we) begin
            rf[issue_uop.rd_addr] <= alu_result;  // seen by the next issue
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (issue) begin
            wb_valid <= 1'b1;
        end else if (wb_ready) begin
            wb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            wb.pc           <= issue_uop.pc;
            wb.rd_addr      <= issue_uop.rd_addr;
            wb.reg_write_en <= issue_uop.reg_write_en;
            wb.data         <= alu_result;
            wb.exc          <= issue_uop.exc;
        end
    end

    // r0 stays zero across any program
    assert property (@(posedge clk) disable iff (!rst_n) rf[0] == '0);

endmodule

`default_nettype wire

// File: rtl/la_alu.sv
`timescale 1ns/1ps
`default_nettype none

module la_alu (
    input  wire la_core_pkg::alu_op_e          op,
    input  wire logic [la_core_pkg::xlen-1:0]  src1,
    input  wire logic [la_core_pkg::xlen-1:0]  src2,
    output logic [la_core_pkg::xlen-1:0]       result
);

    logic signed [2*la_core_pkg::xlen-1:0] prod_s;
    logic        [2*la_core_pkg::xlen-1:0] prod_u;
    logic        [4:0]                     shamt;

    assign prod_s = $signed(src1) * $signed(src2);
    assign prod_u = src1 * src2;
    assign shamt  = src2[4:0];

    always_comb begin
        case (op)
            la_core_pkg::alu_add:   result = src1 + src2;
            la_core_pkg::alu_sub:   result = src1 - src2;
            la_core_pkg::alu_slt: begin
                result = {{(la_core_pkg::xlen - 1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            la_core_pkg::alu_sltu: begin
                result = {{(la_core_pkg::xlen - 1){1'b0}}, src1 < src2};
            end
            la_core_pkg::alu_and:   result = src1 & src2;
            la_core_pkg::alu_or:    result = src1 | src2;
            la_core_pkg::alu_nor:   result = ~(src1 | src2);
            la_core_pkg::alu_xor:   result = src1 ^ src2;
            la_core_pkg::alu_sll:   result = src1 << shamt;
            la_core_pkg::alu_srl:   result = src1 >> shamt;
            la_core_pkg::alu_sra:   result = $signed(src1) >>> shamt;
            la_core_pkg::alu_mul:   result = prod_s[la_core_pkg::xlen-1:0];  // same for both signs
            la_core_pkg::alu_mulh:  result = prod_s[2*la_core_pkg::xlen-1:la_core_pkg::xlen];
            la_core_pkg::alu_mulhu: result = prod_u[2*la_core_pkg::xlen-1:la_core_pkg::xlen];
            la_core_pkg::alu_lui:   result = src2;  // imm already shifted
            default:                result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/la_core_pkg.sv
`default_nettype none

package la_core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

    // wider-immediate formats, matched on their own prefix
    localparam logic [9:0] addi_w_op  = 10'h00a;  // inst[31:22]
    localparam logic [6:0] lu12i_w_op = 7'h0a;    // inst[31:25]

    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_nor,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_mul,
        alu_mulh,
        alu_mulhu,
        alu_lui,
        alu_nop
    } alu_op_e;

    // inst[31:15] of the 3R, 2RI5 and code formats
    typedef enum logic [16:0] {
        op_add_w   = 17'h00020,
        op_sub_w   = 17'h00022,
        op_slt     = 17'h00024,
        op_sltu    = 17'h00025,
        op_nor     = 17'h00028,
        op_and     = 17'h00029,
        op_or      = 17'h0002a,
        op_xor     = 17'h0002b,
        op_sll_w   = 17'h0002e,
        op_srl_w   = 17'h0002f,
        op_sra_w   = 17'h00030,
        op_mul_w   = 17'h00038,
        op_mulh_w  = 17'h00039,
        op_mulh_wu = 17'h0003a,
        op_break   = 17'h00054,
        op_syscall = 17'h00056,
        op_slli_w  = 17'h00081,
        op_srli_w  = 17'h00089,
        op_srai_w  = 17'h00091
    } opcode_e;

    typedef enum logic [2:0] {
        exc_none,
        exc_brk,
        exc_sys,
        exc_ine
    } exc_code_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } fetch_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        alu_op_e               op;
        logic [reg_addr_w-1:0] rj_addr;
        logic [reg_addr_w-1:0] rk_addr;
        logic [reg_addr_w-1:0] rd_addr;
        logic                  use_rk;       // src2 from rk, else imm
        logic [xlen-1:0]       imm;
        logic                  reg_write_en;
        exc_code_e             exc;
    } uop_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd_addr;
        logic                  reg_write_en;
        logic [xlen-1:0]       data;
        exc_code_e             exc;
    } wb_t;

endpackage

`default_nettype wire

// File: rtl/la_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module la_decoder (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                fetch_valid,
    input  wire la_core_pkg::fetch_t fetch,
    output logic                     fetch_ready,
    output logic                     uop_valid,
    output la_core_pkg::uop_t        uop,
    input  wire logic                uop_ready
);

    logic [16:0]       opcode;
    logic [4:0]        ui5;
    la_core_pkg::uop_t dec;

    assign opcode = fetch.inst[31:15];
    assign ui5    = fetch.inst[14:10];

    // slot free or being emptied this cycle
    assign fetch_ready = !uop_valid || uop_ready;

    always_comb begin
        dec              = '0;
        dec.pc           = fetch.pc;
        dec.rk_addr      = fetch.inst[14:10];
        dec.rj_addr      = fetch.inst[9:5];
        dec.rd_addr      = fetch.inst[4:0];
        dec.op           = la_core_pkg::alu_nop;
        dec.use_rk       = 1'b1;
        dec.reg_write_en = 1'b1;
        dec.exc          = la_core_pkg::exc_none;

        case (opcode)
            la_core_pkg::op_add_w:   dec.op = la_core_pkg::alu_add;
            la_core_pkg::op_sub_w:   dec.op = la_core_pkg::alu_sub;
            la_core_pkg::op_slt:     dec.op = la_core_pkg::alu_slt;
            la_core_pkg::op_sltu:    dec.op = la_core_pkg::alu_sltu;
            la_core_pkg::op_nor:     dec.op = la_core_pkg::alu_nor;
            la_core_pkg::op_and:     dec.op = la_core_pkg::alu_and;
            la_core_pkg::op_or:      dec.op = la_core_pkg::alu_or;
            la_core_pkg::op_xor:     dec.op = la_core_pkg::alu_xor;
            la_core_pkg::op_sll_w:   dec.op = la_core_pkg::alu_sll;
            la_core_pkg::op_srl_w:   dec.op = la_core_pkg::alu_srl;
            la_core_pkg::op_sra_w:   dec.op = la_core_pkg::alu_sra;
            la_core_pkg::op_mul_w:   dec.op = la_core_pkg::alu_mul;
            la_core_pkg::op_mulh_w:  dec.op = la_core_pkg::alu_mulh;
            la_core_pkg::op_mulh_wu: dec.op = la_core_pkg::alu_mulhu;
            la_core_pkg::op_slli_w, la_core_pkg::op_srli_w, la_core_pkg::op_srai_w: begin
                dec.use_rk = 1'b0;
                dec.imm    = {27'b0, ui5};  // zero-extended shamt
                if (opcode == la_core_pkg::op_slli_w)
                    dec.op = la_core_pkg::alu_sll;
                else if (opcode == la_core_pkg::op_srli_w)
                    dec.op = la_core_pkg::alu_srl;
                else
                    dec.op = la_core_pkg::alu_sra;
            end
            la_core_pkg::op_break: begin
                dec.reg_write_en = 1'b0;
                dec.exc          = la_core_pkg::exc_brk;
            end
            la_core_pkg::op_syscall: begin
                dec.reg_write_en = 1'b0;
                dec.exc          = la_core_pkg::exc_sys;
            end
            default: begin
                dec.use_rk = 1'b0;
                if (fetch.inst[31:22] == la_core_pkg::addi_w_op) begin
                    dec.op  = la_core_pkg::alu_add;
                    dec.imm = {{20{fetch.inst[21]}}, fetch.inst[21:10]};  // si12
                end else if (fetch.inst[31:25] == la_core_pkg::lu12i_w_op) begin
                    dec.op  = la_core_pkg::alu_lui;
                    dec.imm = {fetch.inst[24:5], 12'b0};  // si20 << 12
                end else begin
                    dec.reg_write_en = 1'b0;
                    dec.exc          = la_core_pkg::exc_ine;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
        end else if (fetch_valid && fetch_ready) begin
            uop_valid <= 1'b1;
        end else if (uop_ready) begin
            uop_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready)
            uop <= dec;
    end

    // held micro-op must not change until the fifo takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        (uop_valid && !uop_ready) |=> (uop_valid && $stable(uop)));

endmodule

`default_nettype wire

// File: rtl/uop_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uop_fifo (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              in_valid,
    input  wire la_core_pkg::uop_t in_uop,
    output logic                   in_ready,
    output logic                   out_valid,
    output la_core_pkg::uop_t      out_uop,
    input  wire logic              out_ready
);

    la_core_pkg::uop_t                  mem [la_core_pkg::fifo_depth];
    logic [la_core_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [la_core_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [la_core_pkg::fifo_cnt_w-1:0] count;
    logic                               push;
    logic                               pop;

    assign in_ready  = (count != la_core_pkg::fifo_depth);  // not full
    assign out_valid = (count != '0);                       // not empty
    assign out_uop   = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == la_core_pkg::fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == la_core_pkg::fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_uop;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        count <= la_core_pkg::fifo_depth);

    // pointers and count agree on occupancy
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_ptr == la_core_pkg::fifo_ptr_w'((rd_ptr + count) % la_core_pkg::fifo_depth));

endmodule

`default_nettype wire

// File: test/tb_ref_model.svh
`ifndef tb_ref_model_svh
`define tb_ref_model_svh

// architectural register file of the model, r0 is never written
logic [31:0] model_rf [32];

function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
                                       input logic [4:0] rj, input logic [4:0] rd);
    return {op, rk, rj, rd};  // ui5 sits in the rk slot
endfunction

function automatic logic [31:0] enc_addi(input logic [11:0] si12, input logic [4:0] rj,
                                         input logic [4:0] rd);
    return {10'h00a, si12, rj, rd};
endfunction

function automatic logic [31:0] enc_lu12i(input logic [19:0] si20, input logic [4:0] rd);
    return {7'h0a, si20, rd};
endfunction

// executes one word in program order and returns its writeback
function automatic la_core_pkg::wb_t predict(input logic [31:0] pc, input logic [31:0] inst);
    la_core_pkg::wb_t w;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [4:0]       ui5;
    logic [63:0]      ps;
    logic [63:0]      pu;
    a   = model_rf[inst[9:5]];
    b   = model_rf[inst[14:10]];
    ui5 = inst[14:10];
    ps  = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // low 64 bits of the signed product
    pu  = {32'b0, a} * {32'b0, b};
    w              = '0;
    w.pc           = pc;
    w.rd_addr      = inst[4:0];
    w.reg_write_en = 1'b1;
    w.exc          = la_core_pkg::exc_none;
    if (inst[31:22] == 10'h00a) begin
        w.data = a + {{20{inst[21]}}, inst[21:10]};
    end else if (inst[31:25] == 7'h0a) begin
        w.data = {inst[24:5], 12'h000};
    end else begin
        case (inst[31:15])
            17'h00020: w.data = a + b;
            17'h00022: w.data = a - b;
            17'h00024: w.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            17'h00025: w.data = (a < b) ? 32'd1 : 32'd0;
            17'h00028: w.data = ~(a | b);
            17'h00029: w.data = a & b;
            17'h0002a: w.data = a | b;
            17'h0002b: w.data = a ^ b;
            17'h0002e: w.data = a << b[4:0];
            17'h0002f: w.data = a >> b[4:0];
            17'h00030: w.data = $signed(a) >>> b[4:0];
            17'h00038: w.data = ps[31:0];
            17'h00039: w.data = ps[63:32];
            17'h0003a: w.data = pu[63:32];
            17'h00081: w.data = a << ui5;
            17'h00089: w.data = a >> ui5;
            17'h00091: w.data = $signed(a) >>> ui5;
            17'h00054: begin
                w.reg_write_en = 1'b0;
                w.exc          = la_core_pkg::exc_brk;
            end
            17'h00056: begin
                w.reg_write_en = 1'b0;
                w.exc          = la_core_pkg::exc_sys;
            end
            default: begin
                w.reg_write_en = 1'b0;
                w.exc          = la_core_pkg::exc_ine;
            end
        endcase
    end
    if (w.reg_write_en && w.rd_addr != 5'd0)
        model_rf[w.rd_addr] = w.data;
    return w;
endfunction

`endif

// File: test/tb_decode_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_exec;

    localparam int clk_period  = 8;
    localparam int total_insts = 24 + 130 + 62 + 62 + 80 + 20;

    logic                clk;
    logic                rst_n;
    logic                fetch_valid;
    la_core_pkg::fetch_t fetch;
    logic                fetch_ready;
    logic                wb_valid;
    la_core_pkg::wb_t    wb;
    logic                wb_ready;

    la_core_pkg::fetch_t fetch_q [$];
    la_core_pkg::wb_t    exp_q [$];
    logic [31:0]         next_pc;
    int                  errors;
    int                  checks;
    int                  failed_tests;
    int                  fetch_count;
    int                  wb_count;
    int                  seed_ret;

    logic [16:0] alu_ops [14] = '{
        la_core_pkg::op_add_w, la_core_pkg::op_sub_w, la_core_pkg::op_slt,
        la_core_pkg::op_sltu, la_core_pkg::op_nor, la_core_pkg::op_and,
        la_core_pkg::op_or, la_core_pkg::op_xor, la_core_pkg::op_sll_w,
        la_core_pkg::op_srl_w, la_core_pkg::op_sra_w, la_core_pkg::op_slli_w,
        la_core_pkg::op_srli_w, la_core_pkg::op_srai_w
    };

    `include "tb_ref_model.svh"

    decode_exec_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .wb_ready    (wb_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", what, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_wb(input string name, input la_core_pkg::wb_t act);
        la_core_pkg::wb_t exp;
        if (exp_q.size() == 0) begin
            $display("ERROR: %s got a writeback for pc %h with none expected", name, act.pc);
            errors++;
        end else begin
            exp = exp_q.pop_front();
            check_value({name, " pc"}, exp.pc, act.pc);
            check_value({name, " rd"}, exp.rd_addr, act.rd_addr);
            check_value({name, " reg_write_en"}, exp.reg_write_en, act.reg_write_en);
            check_value({name, " exc"}, exp.exc, act.exc);
            if (exp.reg_write_en)
                check_value({name, " data"}, exp.data, act.data);
        end
    endtask

    function automatic logic [4:0] rand_reg(input int lo, input int hi);
        return 5'($urandom_range(lo, hi));
    endfunction

    function automatic logic [31:0] rand_alu(input logic [4:0] rd);
        return enc_3r(alu_ops[$urandom_range(0, 13)], rand_reg(0, 31), rand_reg(0, 31), rd);
    endfunction

    task automatic emit(input logic [31:0] inst);
        la_core_pkg::fetch_t f;
        f.pc   = next_pc;
        f.inst = inst;
        fetch_q.push_back(f);
        exp_q.push_back(predict(next_pc, inst));
        next_pc += 4;
    endtask

    // lu12i + addi, upper part rounded for the sign-extended low half
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] hi;
        hi = value[31:12] + {19'b0, value[11]};
        emit(enc_lu12i(hi, rd));
        emit(enc_addi(value[11:0], rd, rd));
    endtask

    task automatic drive_fetch();
        bit taken;
        while (fetch_q.size() > 0) begin
            @(posedge clk);
            taken = fetch_valid && fetch_ready;
            if (taken) begin
                fetch_q.delete(0);
                fetch_count++;
            end
            #1;
            if (taken || !fetch_valid) begin  // held word stays until taken
                fetch_valid = (fetch_q.size() > 0) && ($urandom_range(0, 99) < 75);
                if (fetch_q.size() > 0)
                    fetch = fetch_q[0];
            end
        end
    endtask

    task automatic collect_wb(input string name, input int n, input bit heavy);
        int got;
        int stall;
        got   = 0;
        stall = 0;
        while (got < n) begin
            @(posedge clk);
            if (wb_valid && wb_ready) begin
                compare_wb(name, wb);
                got++;
                wb_count++;
            end
            #1;
            if (stall > 0) begin
                wb_ready = 1'b0;
                stall--;
            end else if (heavy && $urandom_range(0, 7) == 0) begin
                wb_ready = 1'b0;
                stall    = $urandom_range(5, 20);  // long stall
            end else begin
                wb_ready = ($urandom_range(0, 99) < 80);
            end
        end
    endtask

    task automatic run_test(input string name, input bit heavy);
        int n;
        int err0;
        int f0;
        int w0;
        int extra;
        n     = fetch_q.size();
        err0  = errors;
        f0    = fetch_count;
        w0    = wb_count;
        extra = 0;
        fork
            drive_fetch();
            collect_wb(name, n, heavy);
        join
        wb_ready = 1'b1;
        repeat (8) begin
            @(posedge clk);
            if (wb_valid) begin  // nothing may be left in flight
                extra++;
                wb_count++;
            end
        end
        check_value({name, " extra wb"}, 0, extra);
        check_value({name, " transfer count"}, fetch_count - f0, wb_count - w0);
        if (errors != err0)
            failed_tests++;
        $display("test %-14s %0d instructions, %0d errors", name, n, errors - err0);
    endtask

    initial begin
        logic [31:0] value;
        logic [16:0] op;
        int          k;
        seed_ret     = $urandom(32'hb75b_2a6f);
        rst_n        = 1'b0;
        fetch_valid  = 1'b0;
        fetch        = '0;
        wb_ready     = 1'b0;
        next_pc      = 32'h1c00_0000;
        errors       = 0;
        checks       = 0;
        failed_tests = 0;
        fetch_count  = 0;
        wb_count     = 0;
        for (int i = 0; i < 32; i++)
            model_rf[i] = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("reset fetch_ready", 1, fetch_ready);
        check_value("reset wb_valid", 0, wb_valid);

        for (int i = 1; i <= 8; i++) begin
            value = $urandom();
            load_const(i[4:0], value);
        end
        for (int i = 1; i <= 8; i++)
            emit(enc_3r(la_core_pkg::op_add_w, 5'((i % 8) + 1), i[4:0], 5'(i + 8)));
        run_test("const_load", 1'b0);

        for (int i = 1; i <= 15; i++)
            load_const(i[4:0], $urandom());
        for (int i = 0; i < 100; i++)
            emit(rand_alu(rand_reg(0, 31)));
        run_test("alu_random", 1'b0);

        emit(enc_lu12i(20'h80000, 5'd1));
        emit(enc_addi(12'hfff, 5'd0, 5'd2));  // all ones
        for (int i = 0; i < 60; i++) begin
            k  = $urandom_range(0, 2);
            op = (k == 0) ? la_core_pkg::op_mul_w :
                 (k == 1) ? la_core_pkg::op_mulh_w : la_core_pkg::op_mulh_wu;
            emit(enc_3r(op, rand_reg(0, 7), rand_reg(0, 7), rand_reg(3, 31)));
        end
        run_test("multiply", 1'b0);

        for (int i = 0; i < 30; i++) begin
            k     = $urandom_range(0, 2);
            value = $urandom();
            if (k == 0)
                emit({la_core_pkg::op_break, value[14:0]});
            else if (k == 1)
                emit({la_core_pkg::op_syscall, value[14:0]});
            else
                emit({1'b1, value[30:0]});  // bit 31 set is never a valid word here
        end
        for (int i = 0; i < 32; i++)
            emit(enc_3r(la_core_pkg::op_add_w, 5'd0, i[4:0], i[4:0]));
        run_test("exceptions", 1'b0);

        for (int i = 0; i < 80; i++) begin
            if ($urandom_range(0, 3) == 0)
                emit(enc_3r(la_core_pkg::op_mul_w, rand_reg(0, 31), rand_reg(0, 31),
                            rand_reg(0, 31)));
            else
                emit(rand_alu(rand_reg(0, 31)));
        end
        run_test("backpressure", 1'b1);

        for (int i = 0; i < 10; i++) begin
            value = $urandom();
            if (value[0])
                emit(rand_alu(5'd0));
            else
                emit(enc_addi(value[12:1], rand_reg(0, 31), 5'd0));
            emit(enc_3r(la_core_pkg::op_add_w, rand_reg(1, 31), 5'd0, rand_reg(1, 31)));
        end
        run_test("r0_writes", 1'b0);

        $display("summary: 6 tests, %0d failed, %0d checks, %0d errors",
                 failed_tests, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        repeat (total_insts * 40) @(posedge clk);
        $display("ERROR: timeout after %0d cycles, writebacks stopped arriving",
                 total_insts * 40);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
